// File: common/icache_pkg.sv
// instruction cache shared definitions
// cache geometry, address decoding and line storage types
`default_nettype none

package icache_pkg;

    localparam int WAYS         = 4;
    localparam int SETS         = 16;
    localparam int LINE_WORDS   = 4;
    localparam int OFFSET_W     = 4;    // byte offset within a line
    localparam int INDEX_W      = 4;
    localparam int TAG_W        = 24;
    localparam int UNCACHED_BIT = 31;   // set means a single uncached bus read

    typedef logic [TAG_W-1:0]   tag_t;
    typedef logic [INDEX_W-1:0] index_t;
    typedef logic [1:0]         way_t;

    // one cache line, word 0 at the lowest address
    typedef logic [LINE_WORDS-1:0][31:0] line_t;

    // fetch address seen either flat or split for the lookup
    typedef union packed {
        logic [31:0] raw;
        struct packed {
            tag_t       tag;
            index_t     index;
            logic [1:0] word;       // word within the line
            logic [1:0] byte_sel;   // always zero for fetches
        } fields;
    } fetch_addr_u;

endpackage

`default_nettype wire

// File: icache/icache_plru.sv
// tree pseudo-LRU replacement state for the instruction cache
// three bits per set, victim picked by following the tree
`timescale 1ns/1ps
`default_nettype none

module icache_plru (
    input  wire logic              clk,
    input  wire logic              arst_n,
    input  wire logic              clear,
    input  wire logic              touch,
    input  wire icache_pkg::index_t touch_set,
    input  wire icache_pkg::way_t  touch_way,
    input  wire icache_pkg::index_t victim_set,
    output icache_pkg::way_t       victim_way
);
    import icache_pkg::*;

    // bit 0 picks the half, bit 1 ways 0/1, bit 2 ways 2/3
    logic [SETS-1:0][2:0] tree_q;
    logic [2:0]           vic_bits;

    assign vic_bits = tree_q[victim_set];

    assign victim_way = vic_bits[0] ? {1'b1, vic_bits[2]}
                                    : {1'b0, vic_bits[1]};

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            tree_q <= '0;
        end else if (clear) begin
            tree_q <= '0;
        end else if (touch) begin
            // point every node on the path away from the touched way
            tree_q[touch_set][0] <= ~touch_way[1];
            if (touch_way[1]) begin
                tree_q[touch_set][2] <= ~touch_way[0];
            end else begin
                tree_q[touch_set][1] <= ~touch_way[0];
            end
        end
    end

endmodule

`default_nettype wire

// File: icache/icache_bus_master.sv
// wishbone classic read master for line refills and uncached reads
// one beat or four incrementing beats, cyc held across a refill
`timescale 1ns/1ps
`default_nettype none

module icache_bus_master (
    input  wire logic        clk,
    input  wire logic        arst_n,
    input  wire logic        fill_start,
    input  wire logic        fill_single,
    input  wire logic [31:0] fill_addr,
    input  wire logic [31:0] wb_dat_i,
    input  wire logic        wb_ack,
    output logic             wb_cyc,
    output logic             wb_stb,
    output logic [31:0]      wb_adr,
    output logic             word_valid,
    output logic [31:0]      word_data
);
    import icache_pkg::*;

    localparam int BEAT_W = $clog2(LINE_WORDS);

    logic              cyc_q;
    logic              stb_q;
    logic              single_q;
    logic [BEAT_W-1:0] beat_q;
    logic [31:0]       adr_q;
    logic              beat_done;
    logic              last_beat;

    assign beat_done = stb_q && wb_ack;
    assign last_beat = single_q || (beat_q == BEAT_W'(LINE_WORDS - 1));

    assign wb_cyc     = cyc_q;
    assign wb_stb     = stb_q;
    assign wb_adr     = adr_q;
    assign word_valid = beat_done;
    assign word_data  = wb_dat_i;   // only meaningful with word_valid

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cyc_q    <= 1'b0;
            stb_q    <= 1'b0;
            single_q <= 1'b0;
            beat_q   <= '0;
        end else if (fill_start) begin
            cyc_q    <= 1'b1;
            stb_q    <= 1'b1;
            single_q <= fill_single;
            beat_q   <= '0;
        end else if (cyc_q) begin
            if (beat_done) begin
                stb_q <= 1'b0;  // one idle cycle between beats
                if (last_beat) begin
                    cyc_q <= 1'b0;
                end else begin
                    beat_q <= beat_q + 1'b1;
                end
            end else if (!stb_q) begin
                stb_q <= 1'b1;
            end
        end
    end

    // address moves on only while stb is low
    always_ff @(posedge clk) begin
        if (fill_start) begin
            adr_q <= fill_addr;
        end else if (beat_done && !last_beat) begin
            adr_q <= adr_q + 32'd4;
        end
    end

endmodule

`default_nettype wire

// File: icache/icache_core.sv
// instruction cache core
// tag/data arrays, hit check, refill FSM and the fetch port
// uncached fetches bypass the arrays
`timescale 1ns/1ps
`default_nettype none

module icache_core (
    input  wire logic                   clk,
    input  wire logic                   arst_n,
    input  wire logic                   req,
    input  wire icache_pkg::fetch_addr_u addr,
    input  wire logic                   invalidate,
    input  wire logic                   word_valid,
    input  wire logic [31:0]            word_data,
    input  wire icache_pkg::way_t       victim_way,
    output logic                        ready,
    output logic [31:0]                 rdata,
    output logic                        fill_start,
    output logic                        fill_single,
    output logic [31:0]                 fill_addr,
    output logic                        touch,
    output icache_pkg::index_t          touch_set,
    output icache_pkg::way_t            touch_way,
    output icache_pkg::index_t          victim_set,
    output logic                        clear
);
    import icache_pkg::*;

    typedef enum logic [2:0] {
        S_IDLE,
        S_LOOKUP,
        S_FILL,
        S_WRITE,
        S_UNC_WAIT
    } state_t;

    state_t                 state_q;
    state_t                 state_d;
    fetch_addr_u            req_q;
    logic [SETS-1:0][WAYS-1:0] valid_q;
    tag_t                   tag_q [WAYS][SETS];
    line_t                  data_mem [WAYS][SETS];
    line_t                  data_rd [WAYS];
    line_t                  line_q;     // refill assembly, word 0 also holds uncached data
    logic [1:0]             cnt_q;
    logic                   unc_ready_q;
    logic [WAYS-1:0]        hit;
    way_t                   hit_way;
    logic                   is_unc;
    logic                   hit_ready;

    assign is_unc = req_q.raw[UNCACHED_BIT];

    // tags and valids are flops, read at the held request index
    always_comb begin
        hit_way = '0;
        for (int w = 0; w < WAYS; w++) begin
            hit[w] = valid_q[req_q.fields.index][w]
                     && (tag_q[w][req_q.fields.index] == req_q.fields.tag);
            if (hit[w]) begin
                hit_way = way_t'(w);
            end
        end
    end

    assign hit_ready = (state_q == S_LOOKUP) && !is_unc && (|hit);

    assign ready = hit_ready || unc_ready_q;
    assign rdata = unc_ready_q ? line_q[0] : data_rd[hit_way][req_q.fields.word];

    // miss or uncached, the bus gets the request straight from lookup
    assign fill_start  = (state_q == S_LOOKUP) && !hit_ready;
    assign fill_single = is_unc;
    assign fill_addr   = is_unc ? {req_q.raw[31:2], 2'b00}
                                : {req_q.raw[31:OFFSET_W], {OFFSET_W{1'b0}}};

    assign touch      = hit_ready || (state_q == S_WRITE);
    assign touch_set  = req_q.fields.index;
    assign touch_way  = (state_q == S_WRITE) ? victim_way : hit_way;
    assign victim_set = req_q.fields.index;
    assign clear      = (state_q == S_IDLE) && invalidate;

    always_comb begin
        state_d = state_q;
        case (state_q)
            S_IDLE: begin
                if (req) begin
                    state_d = S_LOOKUP;
                end
            end
            S_LOOKUP: begin
                if (hit_ready) begin
                    state_d = S_IDLE;
                end else if (is_unc) begin
                    state_d = S_UNC_WAIT;
                end else begin
                    state_d = S_FILL;
                end
            end
            S_FILL: begin
                if (word_valid && cnt_q == 2'(LINE_WORDS - 1)) begin
                    state_d = S_WRITE;
                end
            end
            S_WRITE: state_d = S_IDLE;  // idle repeats the lookup
            S_UNC_WAIT: begin
                if (unc_ready_q) begin
                    state_d = S_IDLE;
                end
            end
            default: state_d = S_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q     <= S_IDLE;
            valid_q     <= '0;
            cnt_q       <= '0;
            unc_ready_q <= 1'b0;
        end else begin
            state_q     <= state_d;
            unc_ready_q <= (state_q == S_UNC_WAIT) && word_valid;
            if (fill_start) begin
                cnt_q <= '0;
            end else if (word_valid) begin
                cnt_q <= cnt_q + 2'd1;
            end
            if (clear) begin
                valid_q <= '0;
            end else if (state_q == S_WRITE) begin
                valid_q[req_q.fields.index][victim_way] <= 1'b1;
            end
        end
    end

    // request address and line assembly
    always_ff @(posedge clk) begin
        if ((state_q == S_IDLE) && req) begin
            req_q <= addr;
        end
        if (word_valid) begin
            line_q[cnt_q] <= word_data;
        end
    end

    // arrays, read issued from idle at the incoming index
    always_ff @(posedge clk) begin
        if (state_q == S_WRITE) begin
            tag_q[victim_way][req_q.fields.index]    <= req_q.fields.tag;
            data_mem[victim_way][req_q.fields.index] <= line_q;
        end
        if (state_q == S_IDLE) begin
            for (int w = 0; w < WAYS; w++) begin
                data_rd[w] <= data_mem[w][addr.fields.index];
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/icache_top.sv
// instruction cache top level
// core, replacement state and wishbone read master
`timescale 1ns/1ps
`default_nettype none

module icache_top (
    input  wire logic                   clk,
    input  wire logic                   arst_n,
    input  wire logic                   req,
    input  wire icache_pkg::fetch_addr_u addr,
    input  wire logic                   invalidate,
    output logic                        ready,
    output logic [31:0]                 rdata,
    output logic                        wb_cyc,
    output logic                        wb_stb,
    output logic [31:0]                 wb_adr,
    input  wire logic [31:0]            wb_dat_i,
    input  wire logic                   wb_ack
);
    import icache_pkg::*;

    // core to bus master
    logic        fill_start;
    logic        fill_single;
    logic [31:0] fill_addr;
    logic        word_valid;
    logic [31:0] word_data;

    // core to replacement state
    logic        touch;
    index_t      touch_set;
    way_t        touch_way;
    index_t      victim_set;
    way_t        victim_way;
    logic        clear;

    icache_core icache_core_i (
        .clk         (clk),
        .arst_n      (arst_n),
        .req         (req),
        .addr        (addr),
        .invalidate  (invalidate),
        .word_valid  (word_valid),
        .word_data   (word_data),
        .victim_way  (victim_way),
        .ready       (ready),
        .rdata       (rdata),
        .fill_start  (fill_start),
        .fill_single (fill_single),
        .fill_addr   (fill_addr),
        .touch       (touch),
        .touch_set   (touch_set),
        .touch_way   (touch_way),
        .victim_set  (victim_set),
        .clear       (clear)
    );

    icache_plru icache_plru_i (
        .clk        (clk),
        .arst_n     (arst_n),
        .clear      (clear),
        .touch      (touch),
        .touch_set  (touch_set),
        .touch_way  (touch_way),
        .victim_set (victim_set),
        .victim_way (victim_way)
    );

    icache_bus_master icache_bus_master_i (
        .clk         (clk),
        .arst_n      (arst_n),
        .fill_start  (fill_start),
        .fill_single (fill_single),
        .fill_addr   (fill_addr),
        .wb_dat_i    (wb_dat_i),
        .wb_ack      (wb_ack),
        .wb_cyc      (wb_cyc),
        .wb_stb      (wb_stb),
        .wb_adr      (wb_adr),
        .word_valid  (word_valid),
        .word_data   (word_data)
    );

endmodule

`default_nettype wire

// File: tests/icache_assert.sv
// bound checks on the wishbone master and the fetch handshake
// attached to the cache top level
`timescale 1ns/1ps
`default_nettype none

module icache_assert (
    input wire logic                    clk,
    input wire logic                    arst_n,
    input wire logic                    req,
    input wire icache_pkg::fetch_addr_u addr,
    input wire logic                    ready,
    input wire logic                    wb_cyc,
    input wire logic                    wb_stb,
    input wire logic [31:0]             wb_adr,
    input wire logic                    wb_ack
);
    import icache_pkg::*;

    stb_needs_cyc: assert property (@(posedge clk) disable iff (!arst_n)
        wb_stb |-> wb_cyc)
        else $error("wb_stb high without wb_cyc");

    // address held until the slave acks
    adr_stable: assert property (@(posedge clk) disable iff (!arst_n)
        (wb_stb && !wb_ack) |=> $stable(wb_adr))
        else $error("wb_adr changed during a beat");

    ready_needs_req: assert property (@(posedge clk) disable iff (!arst_n)
        ready |-> req)
        else $error("ready high without a request");

    // a cached lookup with no ready the cycle after req rose must go to the bus
    hit_in_one_cycle: assert property (@(posedge clk) disable iff (!arst_n)
        ($past(req, 2) && !$past(req, 3) && !$past(addr.raw[UNCACHED_BIT], 2)
         && !$past(ready)) |-> $rose(wb_cyc))
        else $error("cached lookup neither answered nor started a refill");

endmodule

`default_nettype wire

// File: tests/icache_tb.sv
// testbench for the instruction cache
// wishbone memory model, reference cache model and directed fetch tests
`timescale 1ns/1ps
`default_nettype none

module icache_tb;
    import icache_pkg::*;

    localparam logic [31:0] DATA_KEY = 32'h5a3c_96e1;
    // about 230 fetches, each under 30 cycles with the slowest acks, 3x margin
    localparam int TIMEOUT_CYCLES = 20000;

    logic        clk;
    logic        arst_n;
    logic        req;
    fetch_addr_u addr;
    logic        invalidate;
    logic        ready;
    logic [31:0] rdata;
    logic        wb_cyc;
    logic        wb_stb;
    logic [31:0] wb_adr;
    logic [31:0] wb_dat_i;
    logic        wb_ack;

    int          errors;
    int          checks;
    int          tests_run;
    int          tests_failed;
    int          test_errors_at_start;
    int          beat_count;
    int          cycle_count;
    logic [31:0] beat_adrs[$];

    // reference cache state
    tag_t        ref_tag [SETS][WAYS];
    logic        ref_valid [SETS][WAYS];
    logic [2:0]  ref_tree [SETS];

    icache_top icache_top_i (
        .clk        (clk),
        .arst_n     (arst_n),
        .req        (req),
        .addr       (addr),
        .invalidate (invalidate),
        .ready      (ready),
        .rdata      (rdata),
        .wb_cyc     (wb_cyc),
        .wb_stb     (wb_stb),
        .wb_adr     (wb_adr),
        .wb_dat_i   (wb_dat_i),
        .wb_ack     (wb_ack)
    );

    bind icache_top icache_assert icache_assert_i (
        .clk     (clk),
        .arst_n  (arst_n),
        .req     (req),
        .addr    (addr),
        .ready   (ready),
        .wb_cyc  (wb_cyc),
        .wb_stb  (wb_stb),
        .wb_adr  (wb_adr),
        .wb_ack  (wb_ack)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("run stopped after %0d cycles without finishing", TIMEOUT_CYCLES);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    always @(posedge wb_cyc) cycle_count++;    // bus cycles

    // wishbone slave, 0 to 3 wait states per beat
    task automatic serve_bus();
        int waits;
        forever begin
            @(negedge clk);
            wb_ack = 1'b0;
            if (wb_cyc && wb_stb) begin
                waits = $urandom_range(3, 0);
                repeat (waits) @(negedge clk);
                wb_dat_i = wb_adr ^ DATA_KEY;
                wb_ack   = 1'b1;
                beat_count++;
                beat_adrs.push_back(wb_adr);
            end
        end
    endtask

    function automatic void clear_reference();
        for (int s = 0; s < SETS; s++) begin
            ref_tree[s] = 3'b000;
            for (int w = 0; w < WAYS; w++) begin
                ref_valid[s][w] = 1'b0;
            end
        end
    endfunction

    // bit 0 picks the half, then that half's bit picks the way
    function automatic way_t victim_of_set(input index_t s);
        if (!ref_tree[s][0]) begin
            return ref_tree[s][1] ? 2'd1 : 2'd0;
        end else begin
            return ref_tree[s][2] ? 2'd3 : 2'd2;
        end
    endfunction

    function automatic void touch_tree(input index_t s, input way_t w);
        if (w < 2) begin
            ref_tree[s][0] = 1'b1;          // other half next
            ref_tree[s][1] = (w == 2'd0);
        end else begin
            ref_tree[s][0] = 1'b0;
            ref_tree[s][2] = (w == 2'd2);
        end
    endfunction

    // updates the reference cache, returns the bus beats the fetch should cost
    function automatic int predict_beats(input logic [31:0] a);
        fetch_addr_u fa;
        int          hit_way;
        way_t        w;
        fa.raw  = a;
        hit_way = -1;
        if (fa.raw[UNCACHED_BIT]) begin
            return 1;
        end
        for (int i = 0; i < WAYS; i++) begin
            if (ref_valid[fa.fields.index][i]
                && ref_tag[fa.fields.index][i] == fa.fields.tag) begin
                hit_way = i;
            end
        end
        if (hit_way >= 0) begin
            touch_tree(fa.fields.index, way_t'(hit_way));
            return 0;
        end
        w = victim_of_set(fa.fields.index);
        ref_tag[fa.fields.index][w]   = fa.fields.tag;
        ref_valid[fa.fields.index][w] = 1'b1;
        touch_tree(fa.fields.index, w);
        return LINE_WORDS;
    endfunction

    task automatic check_word(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("ERROR t=%0t %s expected %h actual %h", $time, name, expected, actual);
        end
    endtask

    task automatic check_count(input string name, input int expected, input int actual);
        checks++;
        if (actual != expected) begin
            errors++;
            $display("ERROR t=%0t %s expected %0d actual %0d", $time, name, expected, actual);
        end
    endtask

    task automatic report_test(input string name);
        tests_run++;
        if (errors == test_errors_at_start) begin
            $display("%s: passed", name);
        end else begin
            tests_failed++;
            $display("%s: failed with %0d errors", name, errors - test_errors_at_start);
        end
    endtask

    // one request, held until ready, req low for a cycle after
    task automatic fetch(input logic [31:0] a, output logic [31:0] data, output int latency);
        @(negedge clk);
        latency  = 0;
        req      = 1'b1;
        addr.raw = a;
        do begin
            @(negedge clk);
            latency++;
        end while (!ready);
        data = rdata;
        @(negedge clk);
        req = 1'b0;
    endtask

    task automatic checked_fetch(input logic [31:0] a);
        int          exp_beats;
        int          beats_before;
        int          latency;
        logic [31:0] data;
        exp_beats    = predict_beats(a);
        beats_before = beat_count;
        fetch(a, data, latency);
        check_word("rdata", a ^ DATA_KEY, data);
        check_count("wishbone beats", exp_beats, beat_count - beats_before);
        if (exp_beats == 0) begin
            check_count("hit latency", 1, latency);
        end
    endtask

    task automatic reset_and_first_refill();
        int cycles_before;
        test_errors_at_start = errors;
        check_word("ready", 32'd0, {31'd0, ready});
        check_word("wb_cyc", 32'd0, {31'd0, wb_cyc});
        check_word("wb_stb", 32'd0, {31'd0, wb_stb});
        beat_adrs.delete();
        cycles_before = cycle_count;
        checked_fetch(32'h0000_0100);
        check_count("refill beats", 4, beat_adrs.size());
        check_count("bus cycles", 1, cycle_count - cycles_before);
        for (int i = 0; i < beat_adrs.size(); i++) begin
            check_word("wb_adr", 32'h0000_0100 + 32'(4 * i), beat_adrs[i]);
        end
        report_test("reset and first refill");
    endtask

    task automatic hits_in_filled_line();
        int beats_before;
        test_errors_at_start = errors;
        beats_before = beat_count;
        checked_fetch(32'h0000_0104);
        checked_fetch(32'h0000_0108);
        checked_fetch(32'h0000_010c);
        check_count("beats for line hits", 0, beat_count - beats_before);
        report_test("hits in the filled line");
    endtask

    task automatic repeated_uncached_reads();
        int beats_before;
        test_errors_at_start = errors;
        for (int i = 0; i < 4; i++) begin
            beats_before = beat_count;
            checked_fetch(32'h8000_0040 + 32'(4 * (i % 2)));
            check_count("uncached beats", 1, beat_count - beats_before);
        end
        report_test("uncached reads");
    endtask

    task automatic plru_replacement_one_set();
        int order[11] = '{0, 1, 2, 3, 1, 4, 0, 1, 2, 3, 4};
        test_errors_at_start = errors;
        // five tags, all in set 5
        foreach (order[i]) begin
            checked_fetch(32'h0000_1050 + 32'(order[i] << 8));
        end
        report_test("plru replacement in one set");
    endtask

    task automatic invalidate_and_refill();
        int beats_before;
        test_errors_at_start = errors;
        checked_fetch(32'h0000_0100);
        invalidate = 1'b1;
        @(negedge clk);
        invalidate = 1'b0;
        clear_reference();
        beats_before = beat_count;
        checked_fetch(32'h0000_0100);
        check_count("beats after invalidate", 4, beat_count - beats_before);
        report_test("invalidate");
    endtask

    task automatic random_fetches();
        logic [31:0] a;
        test_errors_at_start = errors;
        for (int i = 0; i < 200; i++) begin
            if ($urandom_range(3, 0) == 0) begin
                a = 32'h8000_0000 | 32'($urandom_range(63, 0) << 2);
            end else begin
                a = 32'($urandom_range(5, 0) << 8) | 32'($urandom_range(3, 0) << 4)
                    | 32'($urandom_range(3, 0) << 2);
            end
            checked_fetch(a);
        end
        report_test("random fetches");
    endtask

    initial begin
        void'($urandom(32));
        arst_n     = 1'b0;
        req        = 1'b0;
        addr       = '0;
        invalidate = 1'b0;
        wb_ack     = 1'b0;
        wb_dat_i   = '0;
        clear_reference();
        fork
            serve_bus();
        join_none
        repeat (16) @(negedge clk);
        arst_n = 1'b1;
        reset_and_first_refill();
        hits_in_filled_line();
        repeated_uncached_reads();
        plru_replacement_one_set();
        invalidate_and_refill();
        random_fetches();
        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: compile.f
common/icache_pkg.sv
icache/icache_plru.sv
icache/icache_bus_master.sv
icache/icache_core.sv
hw/icache_top.sv
tests/icache_assert.sv
tests/icache_tb.sv

// File: run.sh
#!/bin/sh
# build and run the instruction cache testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module icache_tb \
    -f compile.f \
    -o icache_sim

result=$(./obj_dir/icache_sim || true)
echo "$result"

# pass only if the testbench printed its pass line
echo "$result" | grep -qx "TEST RESULT: PASS"
